// File: hw/sys_reg_consts.svh
// Widths, register slot numbers and bit positions of the system register block
// Included by the package and by every module that decodes addresses or bits
`ifndef SYS_REG_CONSTS_SVH
`define SYS_REG_CONSTS_SVH

// Bus geometry fixed by the register map
`define SYS_REG_DATA_W    32
`define SYS_REG_ADDR_W    5
`define SYS_REG_STRB_W    4
// Word slots start above the byte offset
`define SYS_REG_ADDR_LSB  2
`define SYS_REG_IDX_W     3

// Word slot numbers
`define REG_SLOT_CTRL     3'd0
`define REG_SLOT_STAT     3'd1
`define REG_SLOT_TRESP    3'd2
`define REG_SLOT_IREQ     3'd3
`define REG_SLOT_TREQ     3'd4
`define REG_SLOT_IRESP    3'd5
`define REG_SLOT_ADC      3'd6

// Control register bits
`define CTRL_BIT_SRIO_RESET     0
`define CTRL_BIT_SWRITE_BYPASS  1
// ADC sink select bits
`define ADC_BIT_DEST0           0
`define ADC_BIT_DEST1           1

// The only response code this slave returns
`define AXI_RESP_OKAY     2'b00

`endif

// File: hw/sys_reg_pkg.sv
// Shared types of the system register block
// Referenced by scoped name from the channel controllers and the register bank
`include "sys_reg_consts.svh"

package sys_reg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus vectors

  // One bus word
  typedef logic [`SYS_REG_DATA_W-1:0] axil_data_t;
  // Byte address on AW and AR
  typedef logic [`SYS_REG_ADDR_W-1:0] axil_addr_t;
  // One strobe per byte lane
  typedef logic [`SYS_REG_STRB_W-1:0] axil_strb_t;
  // BRESP and RRESP
  typedef logic [1:0]                 axil_resp_t;
  // Word slot number
  typedef logic [`SYS_REG_IDX_W-1:0]  reg_idx_t;
  // SRIO source/destination routing word
  typedef logic [`SYS_REG_DATA_W-1:0] srio_route_t;

  ////////////////////////////////////////////////////////////////////////////
  // Channel state machines

  // Write side waits for AW and W, accepts and holds B
  typedef enum logic [1:0] {WR_IDLE, WR_ACCEPT, WR_RESP} wr_state_t;
  // Read side waits for AR, accepts and holds R
  typedef enum logic [1:0] {RD_IDLE, RD_ACCEPT, RD_DATA} rd_state_t;

endpackage

// File: hw/axil_write_ctrl.sv
// AXI4-Lite write channels of the system register block
// Turns each AW/W pair into one register write command and answers on B
`include "sys_reg_consts.svh"

module axil_write_ctrl
(
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  // Write address channel
  input  sys_reg_pkg::axil_addr_t awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  // Write data channel
  input  sys_reg_pkg::axil_data_t wdata,
  input  sys_reg_pkg::axil_strb_t wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  // Write response channel
  output sys_reg_pkg::axil_resp_t bresp,
  output logic                    bvalid,
  input  logic                    bready,
  // Command to the register bank
  output logic                    wr_en,
  output sys_reg_pkg::reg_idx_t   wr_idx,
  output sys_reg_pkg::axil_data_t wr_data,
  output sys_reg_pkg::axil_strb_t wr_strb
);

  sys_reg_pkg::wr_state_t state;
  sys_reg_pkg::wr_state_t state_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // State machine

  always_comb
  begin
    state_nxt = state;
    case (state)
      // Both valids together while no write is outstanding
      sys_reg_pkg::WR_IDLE:
        if (awvalid && wvalid)
        begin
          state_nxt = sys_reg_pkg::WR_ACCEPT;
        end
      // Handshake closes on this edge
      sys_reg_pkg::WR_ACCEPT:
        state_nxt = sys_reg_pkg::WR_RESP;
      // Hold the response until the master takes it
      sys_reg_pkg::WR_RESP:
        if (bready)
        begin
          state_nxt = sys_reg_pkg::WR_IDLE;
        end
      default:
        state_nxt = sys_reg_pkg::WR_IDLE;
    endcase
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      state <= sys_reg_pkg::WR_IDLE;
    else
      state <= state_nxt;
  end

  // Slot index taken from the byte address as the transfer is accepted
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (state == sys_reg_pkg::WR_IDLE && awvalid && wvalid)
    begin
      wr_idx <= awaddr[`SYS_REG_ADDR_LSB +: `SYS_REG_IDX_W];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs

  // Ready pulse lasts the single accept cycle
  assign awready = (state == sys_reg_pkg::WR_ACCEPT);
  assign wready  = (state == sys_reg_pkg::WR_ACCEPT);

  // W payload is stable until its handshake, so it feeds the bank directly
  assign wr_en   = (state == sys_reg_pkg::WR_ACCEPT);
  assign wr_data = wdata;
  assign wr_strb = wstrb;

  assign bvalid  = (state == sys_reg_pkg::WR_RESP);
  assign bresp   = `AXI_RESP_OKAY;

endmodule

// File: hw/axil_read_ctrl.sv
// AXI4-Lite read channels of the system register block
// Captures the slot index on AR and returns the registered word on R
`include "sys_reg_consts.svh"

module axil_read_ctrl
(
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  // Read address channel
  input  sys_reg_pkg::axil_addr_t araddr,
  input  logic                    arvalid,
  output logic                    arready,
  // Read data channel
  output sys_reg_pkg::axil_data_t rdata,
  output sys_reg_pkg::axil_resp_t rresp,
  output logic                    rvalid,
  input  logic                    rready,
  // Lookup in the register bank
  output sys_reg_pkg::reg_idx_t   rd_idx,
  input  sys_reg_pkg::axil_data_t rd_data
);

  sys_reg_pkg::rd_state_t state;
  sys_reg_pkg::rd_state_t state_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // State machine

  always_comb
  begin
    state_nxt = state;
    case (state)
      sys_reg_pkg::RD_IDLE:
        if (arvalid)
        begin
          state_nxt = sys_reg_pkg::RD_ACCEPT;
        end
      // AR handshake and data capture on the same edge
      sys_reg_pkg::RD_ACCEPT:
        state_nxt = sys_reg_pkg::RD_DATA;
      // Wait out back-pressure on R
      sys_reg_pkg::RD_DATA:
        if (rready)
        begin
          state_nxt = sys_reg_pkg::RD_IDLE;
        end
      default:
        state_nxt = sys_reg_pkg::RD_IDLE;
    endcase
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      state <= sys_reg_pkg::RD_IDLE;
    else
      state <= state_nxt;
  end

  // Slot index latched on entry to RD_ACCEPT, so the bank word settles
  // during the accept cycle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (state == sys_reg_pkg::RD_IDLE && arvalid)
    begin
      rd_idx <= araddr[`SYS_REG_ADDR_LSB +: `SYS_REG_IDX_W];
    end
  end

  // Read word frozen at the handshake and held while rvalid waits
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (state == sys_reg_pkg::RD_ACCEPT)
    begin
      rdata <= rd_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs

  assign arready = (state == sys_reg_pkg::RD_ACCEPT);
  assign rvalid  = (state == sys_reg_pkg::RD_DATA);
  assign rresp   = `AXI_RESP_OKAY;

endmodule

// File: hw/srio_ctrl_regs.sv
// Control and status registers of the SRIO and ADC data path
// Written by the AXI write controller, read through the AXI read controller
`include "sys_reg_consts.svh"

module srio_ctrl_regs
(
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  // Write command
  input  logic                      wr_en,
  input  sys_reg_pkg::reg_idx_t     wr_idx,
  input  sys_reg_pkg::axil_data_t   wr_data,
  input  sys_reg_pkg::axil_strb_t   wr_strb,
  // Read lookup
  input  sys_reg_pkg::reg_idx_t     rd_idx,
  output sys_reg_pkg::axil_data_t   rd_data,
  // SRIO control
  output logic                      srio_reset,
  output logic                      swrite_bypass,
  // SRIO source/destination routing
  output sys_reg_pkg::srio_route_t  srio_srcdest_tresp,
  output sys_reg_pkg::srio_route_t  srio_srcdest_ireq,
  input  sys_reg_pkg::srio_route_t  srio_srcdest_treq,
  input  sys_reg_pkg::srio_route_t  srio_srcdest_iresp,
  // ADC data sink select
  output logic                      adc_sw_dest0,
  output logic                      adc_sw_dest1,
  // Transceiver status
  input  logic                      srio_mode_1x,
  input  logic                      srio_clk_out_lock,
  input  logic                      srio_port_initialized,
  input  logic                      srio_link_initialized
);

  // Writable registers
  sys_reg_pkg::axil_data_t  ctrl_reg;
  sys_reg_pkg::srio_route_t tresp_reg;
  sys_reg_pkg::srio_route_t ireq_reg;
  sys_reg_pkg::axil_data_t  adc_reg;

  // Assembled status word
  sys_reg_pkg::axil_data_t  stat_word;

  // Merge the strobed byte lanes of a new word into an old one
  function automatic sys_reg_pkg::axil_data_t apply_strb(
    input sys_reg_pkg::axil_data_t old_word,
    input sys_reg_pkg::axil_data_t new_word,
    input sys_reg_pkg::axil_strb_t strb
  );
    sys_reg_pkg::axil_data_t merged;
    merged = old_word;
    for (int b = 0; b < `SYS_REG_STRB_W; b++)
    begin
      if (strb[b])
      begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Register writes

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      ctrl_reg  <= '0;
      tresp_reg <= '0;
      ireq_reg  <= '0;
      adc_reg   <= '0;
    end
    else if (wr_en)
    begin
      case (wr_idx)
        `REG_SLOT_CTRL:  ctrl_reg  <= apply_strb(ctrl_reg, wr_data, wr_strb);
        `REG_SLOT_TRESP: tresp_reg <= apply_strb(tresp_reg, wr_data, wr_strb);
        `REG_SLOT_IREQ:  ireq_reg  <= apply_strb(ireq_reg, wr_data, wr_strb);
        `REG_SLOT_ADC:   adc_reg   <= apply_strb(adc_reg, wr_data, wr_strb);
        // Status, inbound routing and slot 7 have no storage
        default:
          ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Status word and read multiplexer

  // Link, port, clock lock, 1x mode from bit 0 up
  always_comb
  begin
    stat_word    = '0;
    stat_word[0] = srio_link_initialized;
    stat_word[1] = srio_port_initialized;
    stat_word[2] = srio_clk_out_lock;
    stat_word[3] = srio_mode_1x;
  end

  always_comb
  begin
    case (rd_idx)
      `REG_SLOT_CTRL:  rd_data = ctrl_reg;
      `REG_SLOT_STAT:  rd_data = stat_word;
      `REG_SLOT_TRESP: rd_data = tresp_reg;
      `REG_SLOT_IREQ:  rd_data = ireq_reg;
      `REG_SLOT_TREQ:  rd_data = srio_srcdest_treq;
      `REG_SLOT_IRESP: rd_data = srio_srcdest_iresp;
      `REG_SLOT_ADC:   rd_data = adc_reg;
      // Unmapped slot reads as zero
      default:         rd_data = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control outputs

  assign srio_reset         = ctrl_reg[`CTRL_BIT_SRIO_RESET];
  assign swrite_bypass      = ctrl_reg[`CTRL_BIT_SWRITE_BYPASS];
  assign srio_srcdest_tresp = tresp_reg;
  assign srio_srcdest_ireq  = ireq_reg;
  assign adc_sw_dest0       = adc_reg[`ADC_BIT_DEST0];
  assign adc_sw_dest1       = adc_reg[`ADC_BIT_DEST1];

endmodule

// File: hw/sys_reg.sv
// System register block of the SRIO and ADC data path, an AXI4-Lite slave
// Joins the write and read channel controllers to the register bank
module sys_reg
(
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  ////////////////////////////////////////////////////////////////////////////
  // AXI4-Lite write channels
  input  sys_reg_pkg::axil_addr_t   s_axi_awaddr,
  input  logic                      s_axi_awvalid,
  output logic                      s_axi_awready,
  input  sys_reg_pkg::axil_data_t   s_axi_wdata,
  input  sys_reg_pkg::axil_strb_t   s_axi_wstrb,
  input  logic                      s_axi_wvalid,
  output logic                      s_axi_wready,
  output sys_reg_pkg::axil_resp_t   s_axi_bresp,
  output logic                      s_axi_bvalid,
  input  logic                      s_axi_bready,
  ////////////////////////////////////////////////////////////////////////////
  // AXI4-Lite read channels
  input  sys_reg_pkg::axil_addr_t   s_axi_araddr,
  input  logic                      s_axi_arvalid,
  output logic                      s_axi_arready,
  output sys_reg_pkg::axil_data_t   s_axi_rdata,
  output sys_reg_pkg::axil_resp_t   s_axi_rresp,
  output logic                      s_axi_rvalid,
  input  logic                      s_axi_rready,
  ////////////////////////////////////////////////////////////////////////////
  // SRIO and ADC side
  output logic                      srio_reset,
  output logic                      swrite_bypass,
  output sys_reg_pkg::srio_route_t  srio_srcdest_tresp,
  output sys_reg_pkg::srio_route_t  srio_srcdest_ireq,
  input  sys_reg_pkg::srio_route_t  srio_srcdest_treq,
  input  sys_reg_pkg::srio_route_t  srio_srcdest_iresp,
  output logic                      adc_sw_dest0,
  output logic                      adc_sw_dest1,
  input  logic                      srio_mode_1x,
  input  logic                      srio_clk_out_lock,
  input  logic                      srio_port_initialized,
  input  logic                      srio_link_initialized
);

  // Write command into the bank
  logic                    wr_en;
  sys_reg_pkg::reg_idx_t   wr_idx;
  sys_reg_pkg::axil_data_t wr_data;
  sys_reg_pkg::axil_strb_t wr_strb;

  // Read lookup, answered combinationally
  sys_reg_pkg::reg_idx_t   rd_idx;
  sys_reg_pkg::axil_data_t rd_data;

  axil_write_ctrl u_write_ctrl
  (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (s_axi_awaddr),
    .awvalid       (s_axi_awvalid),
    .awready       (s_axi_awready),
    .wdata         (s_axi_wdata),
    .wstrb         (s_axi_wstrb),
    .wvalid        (s_axi_wvalid),
    .wready        (s_axi_wready),
    .bresp         (s_axi_bresp),
    .bvalid        (s_axi_bvalid),
    .bready        (s_axi_bready),
    .wr_en         (wr_en),
    .wr_idx        (wr_idx),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb)
  );

  axil_read_ctrl u_read_ctrl
  (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (s_axi_araddr),
    .arvalid       (s_axi_arvalid),
    .arready       (s_axi_arready),
    .rdata         (s_axi_rdata),
    .rresp         (s_axi_rresp),
    .rvalid        (s_axi_rvalid),
    .rready        (s_axi_rready),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data)
  );

  srio_ctrl_regs u_regs
  (
    .S_AXI_ACLK            (S_AXI_ACLK),
    .S_AXI_ARESETN         (S_AXI_ARESETN),
    .wr_en                 (wr_en),
    .wr_idx                (wr_idx),
    .wr_data               (wr_data),
    .wr_strb               (wr_strb),
    .rd_idx                (rd_idx),
    .rd_data               (rd_data),
    .srio_reset            (srio_reset),
    .swrite_bypass         (swrite_bypass),
    .srio_srcdest_tresp    (srio_srcdest_tresp),
    .srio_srcdest_ireq     (srio_srcdest_ireq),
    .srio_srcdest_treq     (srio_srcdest_treq),
    .srio_srcdest_iresp    (srio_srcdest_iresp),
    .adc_sw_dest0          (adc_sw_dest0),
    .adc_sw_dest1          (adc_sw_dest1),
    .srio_mode_1x          (srio_mode_1x),
    .srio_clk_out_lock     (srio_clk_out_lock),
    .srio_port_initialized (srio_port_initialized),
    .srio_link_initialized (srio_link_initialized)
  );

endmodule

// File: tb/sys_reg_properties.sv
// Concurrent handshake checks on the system register block
// Bound to every sys_reg instance
module sys_reg_properties
(
  input logic                    S_AXI_ACLK,
  input logic                    S_AXI_ARESETN,
  input logic                    s_axi_awready,
  input logic                    s_axi_wready,
  input logic                    s_axi_bvalid,
  input logic                    s_axi_bready,
  input sys_reg_pkg::axil_resp_t s_axi_bresp,
  input logic                    s_axi_arready,
  input logic                    s_axi_rvalid,
  input logic                    s_axi_rready,
  input sys_reg_pkg::axil_data_t s_axi_rdata,
  input sys_reg_pkg::axil_resp_t s_axi_rresp
);
  timeunit 1ns;
  timeprecision 1ps;

  // Synchronous reset clears all readies and valids by the next edge
  reset_clears_handshake: assert property (@(posedge S_AXI_ACLK)
    !S_AXI_ARESETN |=> !(s_axi_awready || s_axi_wready || s_axi_bvalid ||
                         s_axi_arready || s_axi_rvalid))
    else $error("Ready or valid high after a reset cycle");

  // B waits for bready with a fixed code
  bvalid_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
    else $error("Write response changed before bready");

  // R waits for rready with word and code frozen
  rvalid_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_rvalid && !s_axi_rready |=>
      s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rresp))
    else $error("Read data changed before rready");

  awready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_awready |=> !s_axi_awready)
    else $error("awready high for more than one cycle");

  wready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_wready |=> !s_axi_wready)
    else $error("wready high for more than one cycle");

endmodule

bind sys_reg sys_reg_properties u_properties
(
  .S_AXI_ACLK    (S_AXI_ACLK),
  .S_AXI_ARESETN (S_AXI_ARESETN),
  .s_axi_awready (s_axi_awready),
  .s_axi_wready  (s_axi_wready),
  .s_axi_bvalid  (s_axi_bvalid),
  .s_axi_bready  (s_axi_bready),
  .s_axi_bresp   (s_axi_bresp),
  .s_axi_arready (s_axi_arready),
  .s_axi_rvalid  (s_axi_rvalid),
  .s_axi_rready  (s_axi_rready),
  .s_axi_rdata   (s_axi_rdata),
  .s_axi_rresp   (s_axi_rresp)
);

// File: tb/tb_sys_reg.sv
// Directed testbench of the system register block
// Runs each test task in turn against the AXI4-Lite slave and prints the verdict
`include "sys_reg_consts.svh"

module tb_sys_reg;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 3;
  localparam int NUM_TESTS    = 6;
  localparam int TEST_CYCLES  = 200;
  // Longest wait on any single handshake
  localparam int HS_LIMIT     = 20;
  // rvalid rises on the 2nd edge after arvalid and is sampled at the 3rd
  localparam int RD_SEEN_EDGE = 3;
  localparam sys_reg_pkg::reg_idx_t CTRL_SLOTS [4] =
    '{`REG_SLOT_CTRL, `REG_SLOT_TRESP, `REG_SLOT_IREQ, `REG_SLOT_ADC};
  localparam sys_reg_pkg::reg_idx_t RO_SLOTS [4] =
    '{`REG_SLOT_STAT, `REG_SLOT_TREQ, `REG_SLOT_IRESP, 3'd7};

  logic S_AXI_ACLK;
  logic S_AXI_ARESETN;
  // AXI4-Lite side
  sys_reg_pkg::axil_addr_t  s_axi_awaddr, s_axi_araddr;
  sys_reg_pkg::axil_data_t  s_axi_wdata, s_axi_rdata;
  sys_reg_pkg::axil_strb_t  s_axi_wstrb;
  sys_reg_pkg::axil_resp_t  s_axi_bresp, s_axi_rresp;
  logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
  logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
  logic s_axi_rvalid, s_axi_rready;
  // SRIO and ADC side
  logic srio_reset, swrite_bypass, adc_sw_dest0, adc_sw_dest1;
  sys_reg_pkg::srio_route_t srio_srcdest_tresp, srio_srcdest_ireq;
  sys_reg_pkg::srio_route_t srio_srcdest_treq, srio_srcdest_iresp;
  logic srio_mode_1x, srio_clk_out_lock, srio_port_initialized, srio_link_initialized;

  integer seed;
  int     errors;
  int     checks;
  // Expected contents of every slot that has storage
  sys_reg_pkg::axil_data_t shadow [0:7];

  sys_reg u_sys_reg (.*);

  initial S_AXI_ACLK = 1'b0;
  always #(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;

  ////////////////////////////////////////////////////////////////////////////
  // Checks and reference model

  task automatic check_value(input string name, input sys_reg_pkg::axil_data_t got,
                             input sys_reg_pkg::axil_data_t exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    checks++;
    assert (ok === 1'b1)
    else
    begin
      errors++;
      $display("%s", what);
    end
  endtask

  function automatic bit is_writable(input sys_reg_pkg::reg_idx_t idx);
    return idx inside {`REG_SLOT_CTRL, `REG_SLOT_TRESP, `REG_SLOT_IREQ, `REG_SLOT_ADC};
  endfunction

  // Strobed bytes replace the old ones and other slots keep nothing
  function automatic void model_write(input sys_reg_pkg::reg_idx_t idx,
                                      input sys_reg_pkg::axil_data_t data,
                                      input sys_reg_pkg::axil_strb_t strb);
    sys_reg_pkg::axil_data_t mask;
    mask = '0;
    for (int b = 0; b < `SYS_REG_STRB_W; b++)
    begin
      if (strb[b])
        mask = mask | (32'hff << (8 * b));
    end
    if (is_writable(idx))
      shadow[idx] = (shadow[idx] & ~mask) | (data & mask);
  endfunction

  function automatic sys_reg_pkg::axil_data_t expected_read(input sys_reg_pkg::reg_idx_t idx);
    sys_reg_pkg::axil_data_t word;
    word = '0;
    if (idx == `REG_SLOT_STAT)
      word[3:0] = {srio_mode_1x, srio_clk_out_lock, srio_port_initialized,
                   srio_link_initialized};
    else if (idx == `REG_SLOT_TREQ)
      word = srio_srcdest_treq;
    else if (idx == `REG_SLOT_IRESP)
      word = srio_srcdest_iresp;
    else if (is_writable(idx))
      word = shadow[idx];
    return word;
  endfunction

  task automatic check_outputs();
    check_value("srio_reset/swrite_bypass", {30'd0, swrite_bypass, srio_reset},
                {30'd0, shadow[`REG_SLOT_CTRL][`CTRL_BIT_SWRITE_BYPASS],
                 shadow[`REG_SLOT_CTRL][`CTRL_BIT_SRIO_RESET]});
    check_value("srio_srcdest_tresp", srio_srcdest_tresp, shadow[`REG_SLOT_TRESP]);
    check_value("srio_srcdest_ireq", srio_srcdest_ireq, shadow[`REG_SLOT_IREQ]);
    check_value("adc_sw_dest1/adc_sw_dest0", {30'd0, adc_sw_dest1, adc_sw_dest0},
                {30'd0, shadow[`REG_SLOT_ADC][`ADC_BIT_DEST1],
                 shadow[`REG_SLOT_ADC][`ADC_BIT_DEST0]});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus transfers entered and left just after a rising edge

  task automatic axi_write(input sys_reg_pkg::reg_idx_t idx, input sys_reg_pkg::axil_data_t data,
                           input sys_reg_pkg::axil_strb_t strb, input int stall);
    int waited;
    waited = 0;
    s_axi_awaddr  <= {idx, 2'b00};
    s_axi_awvalid <= 1'b1;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= strb;
    s_axi_wvalid  <= 1'b1;
    // AW and W close together on the single ready cycle
    do
    begin
      @(posedge S_AXI_ACLK);
      waited++;
    end
    while (!(s_axi_awready && s_axi_wready) && waited < HS_LIMIT);
    check_true(s_axi_awready && s_axi_wready, "Write address/data handshake timed out");
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid  <= 1'b0;
    waited = 0;
    do
    begin
      @(posedge S_AXI_ACLK);
      waited++;
    end
    while (!s_axi_bvalid && waited < HS_LIMIT);
    check_true(s_axi_bvalid, "No write response after the write handshake");
    // B held back by the master
    repeat (stall)
    begin
      @(posedge S_AXI_ACLK);
      check_true(s_axi_bvalid, "bvalid dropped while bready was low");
    end
    check_value("s_axi_bresp", 32'(s_axi_bresp), 32'(`AXI_RESP_OKAY));
    s_axi_bready <= 1'b1;
    @(posedge S_AXI_ACLK);
    s_axi_bready <= 1'b0;
  endtask

  task automatic axi_read(input sys_reg_pkg::reg_idx_t idx, input int stall,
                          output sys_reg_pkg::axil_data_t data);
    int edges;
    edges = 0;
    s_axi_araddr  <= {idx, 2'b00};
    s_axi_arvalid <= 1'b1;
    do
    begin
      @(posedge S_AXI_ACLK);
      edges++;
    end
    while (!s_axi_arready && edges < HS_LIMIT);
    check_true(s_axi_arready, "Read address handshake timed out");
    s_axi_arvalid <= 1'b0;
    do
    begin
      @(posedge S_AXI_ACLK);
      edges++;
    end
    while (!s_axi_rvalid && edges < 2 * HS_LIMIT);
    check_true(s_axi_rvalid, "No read data after the read address handshake");
    check_value("rvalid edge count", 32'(edges), 32'(RD_SEEN_EDGE));
    check_value("s_axi_rresp", 32'(s_axi_rresp), 32'(`AXI_RESP_OKAY));
    data = s_axi_rdata;
    repeat (stall)
    begin
      @(posedge S_AXI_ACLK);
      check_true(s_axi_rvalid, "rvalid dropped while rready was low");
      check_value("s_axi_rdata (held)", s_axi_rdata, data);
    end
    s_axi_rready <= 1'b1;
    @(posedge S_AXI_ACLK);
    s_axi_rready <= 1'b0;
  endtask

  task automatic read_check(input sys_reg_pkg::reg_idx_t idx, input int stall);
    sys_reg_pkg::axil_data_t data;
    axi_read(idx, stall, data);
    check_value($sformatf("s_axi_rdata slot %0d", idx), data, expected_read(idx));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests

  task automatic test_reset_values();
    check_outputs();
    for (int i = 0; i < 4; i++)
      read_check(CTRL_SLOTS[i], 0);
  endtask

  // Low control bits run 01 then 10 and each bit takes both values
  task automatic test_full_write();
    sys_reg_pkg::axil_data_t data;
    for (int round = 0; round < 2; round++)
    begin
      for (int i = 0; i < 4; i++)
      begin
        data = $random(seed);
        data[1:0] = (round == 0) ? 2'b01 : 2'b10;
        axi_write(CTRL_SLOTS[i], data, 4'hf, 0);
        model_write(CTRL_SLOTS[i], data, 4'hf);
        read_check(CTRL_SLOTS[i], 0);
      end
      check_outputs();
    end
  endtask

  task automatic test_partial_strobe();
    sys_reg_pkg::axil_data_t data;
    logic [31:0] rnd;
    for (int i = 0; i < 4; i++)
    begin
      // Known old value first
      data = $random(seed);
      axi_write(CTRL_SLOTS[i], data, 4'hf, 0);
      model_write(CTRL_SLOTS[i], data, 4'hf);
      repeat (3)
      begin
        rnd  = $random(seed);
        data = $random(seed);
        axi_write(CTRL_SLOTS[i], data, rnd[3:0], 0);
        model_write(CTRL_SLOTS[i], data, rnd[3:0]);
        read_check(CTRL_SLOTS[i], 0);
      end
    end
    check_outputs();
  endtask

  task automatic test_read_only_slots();
    logic [31:0] rnd;
    // One status input at a time pins down each bit position
    for (int b = 0; b < 4; b++)
    begin
      {srio_mode_1x, srio_clk_out_lock, srio_port_initialized, srio_link_initialized} <=
        4'(1 << b);
      read_check(`REG_SLOT_STAT, 0);
    end
    rnd = $random(seed);
    {srio_mode_1x, srio_clk_out_lock, srio_port_initialized, srio_link_initialized} <= rnd[3:0];
    srio_srcdest_treq  <= $random(seed);
    srio_srcdest_iresp <= $random(seed);
    for (int i = 0; i < 4; i++)
      read_check(RO_SLOTS[i], 0);
    // No storage behind these slots so nothing may move
    for (int i = 0; i < 4; i++)
    begin
      rnd = $random(seed);
      axi_write(RO_SLOTS[i], rnd, 4'hf, 0);
    end
    for (int i = 0; i < 4; i++)
    begin
      read_check(RO_SLOTS[i], 0);
      read_check(CTRL_SLOTS[i], 0);
    end
    check_outputs();
  endtask

  task automatic test_write_backpressure();
    sys_reg_pkg::axil_data_t data;
    logic [31:0] rnd;
    repeat (4)
    begin
      rnd  = $random(seed);
      data = $random(seed);
      axi_write(CTRL_SLOTS[rnd[5:4]], data, 4'hf, 2 + int'(rnd[2:0]));
      model_write(CTRL_SLOTS[rnd[5:4]], data, 4'hf);
      read_check(CTRL_SLOTS[rnd[5:4]], 0);
    end
    check_outputs();
  endtask

  task automatic test_read_backpressure();
    logic [31:0] rnd;
    repeat (6)
    begin
      rnd = $random(seed);
      read_check(rnd[6:4], 2 + int'(rnd[2:0]));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence and verdict

  initial
  begin
    seed   = 32'h82b1c175;
    errors = 0;
    checks = 0;
    foreach (shadow[i])
      shadow[i] = '0;
    S_AXI_ARESETN <= 1'b0;
    s_axi_awaddr  <= '0;
    s_axi_awvalid <= 1'b0;
    s_axi_wdata   <= '0;
    s_axi_wstrb   <= '0;
    s_axi_wvalid  <= 1'b0;
    s_axi_bready  <= 1'b0;
    s_axi_araddr  <= '0;
    s_axi_arvalid <= 1'b0;
    s_axi_rready  <= 1'b0;
    srio_srcdest_treq  <= '0;
    srio_srcdest_iresp <= '0;
    {srio_mode_1x, srio_clk_out_lock, srio_port_initialized, srio_link_initialized} <= 4'h0;
    repeat (RESET_CYCLES) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;
    @(posedge S_AXI_ACLK);
    test_reset_values();
    test_full_write();
    test_partial_strobe();
    test_read_only_slots();
    test_write_backpressure();
    test_read_backpressure();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Cycle budget of every test
  initial
  begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, tests did not finish",
             NUM_TESTS * TEST_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+hw
hw/sys_reg_pkg.sv
hw/axil_write_ctrl.sv
hw/axil_read_ctrl.sv
hw/srio_ctrl_regs.sv
hw/sys_reg.sv
tb/sys_reg_properties.sv
tb/tb_sys_reg.sv

// File: Makefile
# Verilator build, run, lint and clean for the system register block

VERILATOR  ?= verilator
TOP        := tb_sys_reg
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The verdict comes from the log, not from the exit code of the simulator
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST OK" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
